// ==== logic/sim_pkg.sv ====
`default_nettype none

package sim_pkg;

	// Widths
	localparam int COORD_W = 10;
	localparam int ADDR_W = 19;
	localparam int COUNT_W = 4;
	localparam int LFSR_W = 13;

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [ADDR_W-1:0] pixel_addr_t;
	// RGB332
	typedef logic [7:0] color_t;

	// Screen geometry
	localparam coord_t SCREEN_WIDTH = 10'd640;
	localparam coord_t SCREEN_HEIGHT = 10'd480;
	localparam coord_t CENTER_X = 10'd320;
	localparam coord_t CENTER_Y = 10'd240;

	// Limits and credits
	localparam int MAX_PARTICLES = 8;
	localparam int SINK_CREDITS = 4;
	localparam int WRITER_DEPTH = 4;

	localparam color_t COLOR_BLACK = 8'h00;
	localparam color_t COLOR_WHITE = 8'hFF;

	// Up is toward larger y
	typedef enum logic [1:0] {
		heading_left,
		heading_up,
		heading_right,
		heading_down
	} heading_t;

	typedef enum logic [2:0] {
		phase_seed,
		phase_outline,
		phase_idle,
		phase_erase,
		phase_move
	} phase_t;

endpackage

`default_nettype wire

// ==== logic/pixel_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Pixel requests toward the writer, one credit back per freed slot
interface pixel_if;
	import sim_pkg::*;

	logic valid;
	coord_t x;
	coord_t y;
	color_t color;
	logic credit;

	modport source (output valid, output x, output y, output color, input credit);
	modport sink (input valid, input x, input y, input color, output credit);
endinterface

`default_nettype wire

// ==== logic/particle_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One particle's state on its way to or from the step stage
interface particle_if;
	import sim_pkg::*;

	logic valid;
	logic [COUNT_W-1:0] index;
	coord_t x;
	coord_t y;
	heading_t heading;
	// Only meaningful on responses
	logic wall_hit;

	modport sender (output valid, output index, output x, output y, output heading,
		output wall_hit);
	modport receiver (input valid, input index, input x, input y, input heading,
		input wall_hit);
endinterface

`default_nettype wire

// ==== logic/lfsr_seeder.sv ====
`timescale 1ns/100ps
`default_nettype none

module lfsr_seeder (
	input  logic clock,
	input  logic reset,
	input  logic enable,
	output logic [sim_pkg::LFSR_W-1:0] word,
	output logic word_ready
);
	import sim_pkg::*;

	logic [LFSR_W-1:0] lfsr;
	logic [LFSR_W-1:0] lfsr_next;
	logic [3:0] shift_cnt;
	logic feedback;
	logic last_shift;

	// Fibonacci taps 12, 3, 2, 0
	assign feedback = lfsr[12] ^ lfsr[3] ^ lfsr[2] ^ lfsr[0];
	assign lfsr_next = {lfsr[LFSR_W-2:0], feedback};
	// Thirteenth shift of the current word
	assign last_shift = shift_cnt == 4'(LFSR_W - 1);

	always_ff @(posedge clock) begin
		if (reset || !enable) begin
			lfsr <= 13'h000F;
			shift_cnt <= '0;
			word_ready <= 1'b0;
		end else begin
			lfsr <= lfsr_next;
			shift_cnt <= last_shift ? '0 : shift_cnt + 4'd1;
			word_ready <= last_shift;
		end
	end

	// Captured together with the ready pulse
	always_ff @(posedge clock) begin
		if (enable && last_shift) begin
			word <= lfsr_next;
		end
	end

endmodule

`default_nettype wire

// ==== logic/particle_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module particle_sequencer (
	input  logic clock,
	input  logic reset,
	input  logic step,
	input  logic [sim_pkg::COUNT_W-1:0] num_particles,
	input  sim_pkg::coord_t box_width,
	input  logic [sim_pkg::LFSR_W-1:0] word,
	input  logic word_ready,
	output logic seed_enable,
	pixel_if.source pix,
	particle_if.sender req,
	particle_if.receiver rsp,
	output logic step_done,
	output logic [sim_pkg::COUNT_W-1:0] wall_hits
);
	import sim_pkg::*;

	typedef logic [$clog2(WRITER_DEPTH+1)-1:0] credit_t;
	typedef logic [$clog2(MAX_PARTICLES)-1:0] slot_t;

	// Particle register file
	coord_t x_q [MAX_PARTICLES];
	coord_t y_q [MAX_PARTICLES];
	heading_t head_q [MAX_PARTICLES];

	phase_t phase;
	logic [COUNT_W-1:0] n_lim;
	logic [COUNT_W-1:0] idx;
	logic [COUNT_W-1:0] rsp_cnt;
	logic [COUNT_W-1:0] hit_cnt;
	logic [1:0] seed_field;
	logic [1:0] side;
	coord_t run;
	credit_t credits;
	slot_t slot;
	slot_t rsp_slot;
	coord_t half;
	coord_t lo_x;
	coord_t hi_x;
	coord_t lo_y;
	coord_t hi_y;
	coord_t mask;
	coord_t cur_x;
	coord_t cur_y;
	coord_t out_x;
	coord_t out_y;
	logic on_outline;
	logic spend;

	////////////////////
	// Box geometry
	////////////////////

	assign n_lim = (num_particles > COUNT_W'(MAX_PARTICLES)) ? COUNT_W'(MAX_PARTICLES)
		: num_particles;
	assign half = box_width >> 1;
	assign lo_x = CENTER_X - half;
	assign hi_x = CENTER_X + half;
	assign lo_y = CENTER_Y - half;
	assign hi_y = CENTER_Y + half;
	// Seed spread grows with the box
	assign mask = (box_width < 10'd70) ? 10'd31 : (box_width < 10'd135) ? 10'd63
		: (box_width < 10'd265) ? 10'd127 : 10'd255;

	assign slot = slot_t'(idx);
	assign rsp_slot = slot_t'(rsp.index);
	assign cur_x = x_q[slot];
	assign cur_y = y_q[slot];
	// Erasing here would punch a hole in the outline
	assign on_outline = (cur_x == lo_x) || (cur_x == hi_x) || (cur_y == lo_y) || (cur_y == hi_y);
	assign seed_enable = phase == phase_seed;

	// Outline side order top, bottom, left, right
	always_comb begin
		out_x = lo_x + run;
		out_y = lo_y + run;
		case (side)
			2'd0: out_y = lo_y;
			2'd1: out_y = hi_y;
			2'd2: out_x = lo_x;
			default: out_x = hi_x;
		endcase
	end

	// One credit per pixel; moves reserve theirs at request time
	always_comb begin
		case (phase)
			phase_outline: spend = (credits != '0) && (run != box_width);
			phase_erase: spend = (credits != '0) && (idx != n_lim) && !on_outline;
			phase_move: spend = (credits != '0) && (idx != n_lim);
			default: spend = 1'b0;
		endcase
	end

	////////////////////
	// Phase FSM
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= phase_seed;
			idx <= '0;
			rsp_cnt <= '0;
			hit_cnt <= '0;
			seed_field <= '0;
			side <= '0;
			run <= '0;
			credits <= credit_t'(WRITER_DEPTH);
			pix.valid <= 1'b0;
			req.valid <= 1'b0;
			step_done <= 1'b0;
			wall_hits <= '0;
		end else begin
			pix.valid <= 1'b0;
			req.valid <= 1'b0;
			step_done <= 1'b0;
			credits <= credits - credit_t'(spend) + credit_t'(pix.credit);
			case (phase)
				phase_seed: begin
					// All x, then all y, then all headings
					if (idx == n_lim) begin
						idx <= '0;
						seed_field <= seed_field + 2'd1;
						if (seed_field == 2'd2) begin
							phase <= phase_outline;
						end
					end else if (word_ready) begin
						idx <= idx + COUNT_W'(1);
					end
				end
				phase_outline: begin
					if (run == box_width) begin
						run <= '0;
						side <= side + 2'd1;
						if (side == 2'd3) begin
							phase <= phase_idle;
						end
					end else if (spend) begin
						run <= run + coord_t'(1);
						pix.valid <= 1'b1;
					end
				end
				phase_idle: begin
					if (step) begin
						phase <= phase_erase;
					end
				end
				phase_erase: begin
					if (idx == n_lim) begin
						idx <= '0;
						rsp_cnt <= '0;
						hit_cnt <= '0;
						phase <= phase_move;
					end else if (spend || on_outline) begin
						idx <= idx + COUNT_W'(1);
						pix.valid <= spend;
					end
				end
				phase_move: begin
					if (spend) begin
						idx <= idx + COUNT_W'(1);
						req.valid <= 1'b1;
					end
					if (rsp.valid) begin
						rsp_cnt <= rsp_cnt + COUNT_W'(1);
						hit_cnt <= hit_cnt + COUNT_W'(rsp.wall_hit);
						pix.valid <= 1'b1;
					end
					// Done once every response is drawn and the writer has drained
					if (rsp_cnt == n_lim && credits == credit_t'(WRITER_DEPTH)) begin
						idx <= '0;
						step_done <= 1'b1;
						wall_hits <= hit_cnt;
						phase <= phase_idle;
					end
				end
				default: phase <= phase_idle;
			endcase
		end
	end

	////////////////////
	// Particle and pixel data
	////////////////////

	always_ff @(posedge clock) begin
		if (phase == phase_seed && word_ready && idx != n_lim) begin
			case (seed_field)
				2'd0: x_q[slot] <= (coord_t'(word) & mask) + lo_x;
				2'd1: y_q[slot] <= (coord_t'(word) & mask) + lo_y;
				default: head_q[slot] <= heading_t'(word[1:0]);
			endcase
		end
		if (phase == phase_move && rsp.valid) begin
			x_q[rsp_slot] <= rsp.x;
			y_q[rsp_slot] <= rsp.y;
			head_q[rsp_slot] <= rsp.heading;
		end
		case (phase)
			phase_outline: begin
				pix.x <= out_x;
				pix.y <= out_y;
				pix.color <= COLOR_WHITE;
			end
			phase_erase: begin
				pix.x <= cur_x;
				pix.y <= cur_y;
				pix.color <= COLOR_BLACK;
			end
			default: begin
				pix.x <= rsp.x;
				pix.y <= rsp.y;
				pix.color <= COLOR_WHITE;
			end
		endcase
		req.index <= idx;
		req.x <= cur_x;
		req.y <= cur_y;
		req.heading <= head_q[slot];
	end

endmodule

`default_nettype wire

// ==== logic/particle_step.sv ====
`timescale 1ns/100ps
`default_nettype none

module particle_step (
	input  logic clock,
	input  logic reset,
	input  sim_pkg::coord_t speed,
	input  sim_pkg::coord_t box_width,
	particle_if.receiver req,
	particle_if.sender rsp
);
	import sim_pkg::*;

	// Room for overshoot past either edge of the screen
	typedef logic signed [COORD_W+1:0] wide_t;

	wide_t half;
	wide_t lo_x;
	wide_t hi_x;
	wide_t lo_y;
	wide_t hi_y;
	wide_t pos_x;
	wide_t pos_y;
	wide_t dx;
	wide_t dy;
	wide_t cand_x;
	wide_t cand_y;
	wide_t move_x;
	wide_t move_y;
	logic horizontal;
	logic hit_x;
	logic hit_y;
	heading_t new_heading;

	// Keep strictly inside the walls
	function automatic coord_t clamp(input wide_t pos, input wide_t lo, input wide_t hi);
		wide_t result;
		if (pos <= lo) begin
			result = lo + wide_t'(1);
		end else if (pos >= hi) begin
			result = hi - wide_t'(1);
		end else begin
			result = pos;
		end
		return coord_t'(result);
	endfunction

	assign half = wide_t'(box_width >> 1);
	assign lo_x = wide_t'(CENTER_X) - half;
	assign hi_x = wide_t'(CENTER_X) + half;
	assign lo_y = wide_t'(CENTER_Y) - half;
	assign hi_y = wide_t'(CENTER_Y) + half;
	assign pos_x = wide_t'(req.x);
	assign pos_y = wide_t'(req.y);
	assign horizontal = (req.heading == heading_left) || (req.heading == heading_right);

	// Displacement along the current heading
	always_comb begin
		dx = '0;
		dy = '0;
		case (req.heading)
			heading_left: dx = -wide_t'(speed);
			heading_right: dx = wide_t'(speed);
			heading_up: dy = wide_t'(speed);
			default: dy = -wide_t'(speed);
		endcase
	end

	assign cand_x = pos_x + dx;
	assign cand_y = pos_y + dy;
	// Only the axis of travel can bounce
	assign hit_x = horizontal && ((cand_x >= hi_x) || (cand_x <= lo_x));
	assign hit_y = !horizontal && ((cand_y >= hi_y) || (cand_y <= lo_y));
	assign move_x = hit_x ? pos_x - dx : cand_x;
	assign move_y = hit_y ? pos_y - dy : cand_y;

	always_comb begin
		new_heading = req.heading;
		if (hit_x || hit_y) begin
			case (req.heading)
				heading_left: new_heading = heading_right;
				heading_right: new_heading = heading_left;
				heading_up: new_heading = heading_down;
				default: new_heading = heading_up;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rsp.valid <= 1'b0;
		end else begin
			rsp.valid <= req.valid;
		end
	end

	always_ff @(posedge clock) begin
		rsp.index <= req.index;
		rsp.x <= clamp(move_x, lo_x, hi_x);
		rsp.y <= clamp(move_y, lo_y, hi_y);
		rsp.heading <= new_heading;
		rsp.wall_hit <= hit_x || hit_y;
	end

endmodule

`default_nettype wire

// ==== logic/pixel_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_writer (
	input  logic clock,
	input  logic reset,
	pixel_if.sink pix,
	output logic pixel_valid,
	output sim_pkg::pixel_addr_t pixel_addr,
	output sim_pkg::color_t pixel_color,
	input  logic pixel_credit
);
	import sim_pkg::*;

	typedef logic [$clog2(WRITER_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(WRITER_DEPTH+1)-1:0] fill_t;
	typedef logic [$clog2(SINK_CREDITS+1)-1:0] sink_credit_t;

	// FIFO storage
	pixel_addr_t addr_mem [WRITER_DEPTH];
	color_t color_mem [WRITER_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	fill_t fill;
	sink_credit_t sink_credits;
	pixel_addr_t push_addr;
	logic pop;

	// Row major framebuffer address
	assign push_addr = pixel_addr_t'(pix.y) * pixel_addr_t'(SCREEN_WIDTH) + pixel_addr_t'(pix.x);
	// Drain only while the framebuffer has room
	assign pop = (fill != '0) && (sink_credits != '0);

	always_ff @(posedge clock) begin
		if (pix.valid) begin
			addr_mem[wr_ptr] <= push_addr;
			color_mem[wr_ptr] <= pix.color;
		end
		if (pop) begin
			pixel_addr <= addr_mem[rd_ptr];
			pixel_color <= color_mem[rd_ptr];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			sink_credits <= sink_credit_t'(SINK_CREDITS);
			pixel_valid <= 1'b0;
			pix.credit <= 1'b0;
		end else begin
			if (pix.valid) begin
				wr_ptr <= wr_ptr + ptr_t'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			fill <= fill + fill_t'(pix.valid) - fill_t'(pop);
			sink_credits <= sink_credits - sink_credit_t'(pop) + sink_credit_t'(pixel_credit);
			pixel_valid <= pop;
			// Slot freed, hand it back upstream
			pix.credit <= pop;
		end
	end

endmodule

`default_nettype wire

// ==== logic/particle_box_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module particle_box_top (
	input  logic clock,
	input  logic reset,
	input  logic step,
	input  logic [sim_pkg::COUNT_W-1:0] num_particles,
	input  sim_pkg::coord_t box_width,
	input  sim_pkg::coord_t speed,
	input  logic pixel_credit,
	output logic pixel_valid,
	output sim_pkg::pixel_addr_t pixel_addr,
	output sim_pkg::color_t pixel_color,
	output logic step_done,
	output logic [sim_pkg::COUNT_W-1:0] wall_hits
);
	import sim_pkg::*;

	////////////////////
	// Internal buses
	////////////////////

	logic [LFSR_W-1:0] seed_word;
	logic seed_ready;
	logic seed_enable;

	pixel_if pix_bus ();
	// Requests out and responses back overlap by one cycle
	particle_if step_req ();
	particle_if step_rsp ();

	////////////////////
	// Pipeline
	////////////////////

	lfsr_seeder lfsr_seeder_inst (
		.clock(clock),
		.reset(reset),
		.enable(seed_enable),
		.word(seed_word),
		.word_ready(seed_ready)
	);

	particle_sequencer particle_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.step(step),
		.num_particles(num_particles),
		.box_width(box_width),
		.word(seed_word),
		.word_ready(seed_ready),
		.seed_enable(seed_enable),
		.pix(pix_bus.source),
		.req(step_req.sender),
		.rsp(step_rsp.receiver),
		.step_done(step_done),
		.wall_hits(wall_hits)
	);

	particle_step particle_step_inst (
		.clock(clock),
		.reset(reset),
		.speed(speed),
		.box_width(box_width),
		.req(step_req.receiver),
		.rsp(step_rsp.sender)
	);

	pixel_writer pixel_writer_inst (
		.clock(clock),
		.reset(reset),
		.pix(pix_bus.sink),
		.pixel_valid(pixel_valid),
		.pixel_addr(pixel_addr),
		.pixel_color(pixel_color),
		.pixel_credit(pixel_credit)
	);

endmodule

`default_nettype wire

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference model of the particle box
// Heading codes follow the enum order left, up, right, down

// One Fibonacci shift with taps 12 3 2 0
function automatic logic [12:0] lfsr_advance(input logic [12:0] state);
	logic feedback;
	feedback = state[12] ^ state[3] ^ state[2] ^ state[0];
	return {state[11:0], feedback};
endfunction

// Thirteen shifts per random word
function automatic logic [12:0] next_word(input logic [12:0] state);
	logic [12:0] value;
	value = state;
	repeat (13) value = lfsr_advance(value);
	return value;
endfunction

// Seed spread by box size
function automatic int seed_mask(input int width);
	return (width < 70) ? 31 : (width < 135) ? 63 : (width < 265) ? 127 : 255;
endfunction

// All x then all y then all headings with one word each
task automatic seed_model(input int count, input int width);
	logic [12:0] state;
	int half;
	int i;
	state = 13'h000F;
	half = width / 2;
	for (i = 0; i < count; i++) begin
		state = next_word(state);
		m_x[i] = (int'(state) & seed_mask(width)) + int'(CENTER_X) - half;
	end
	for (i = 0; i < count; i++) begin
		state = next_word(state);
		m_y[i] = (int'(state) & seed_mask(width)) + int'(CENTER_Y) - half;
	end
	for (i = 0; i < count; i++) begin
		state = next_word(state);
		m_h[i] = int'(state) & 3;
	end
endtask

// Address of the n-th outline write in top, bottom, left, right order
function automatic int outline_addr(input int width, input int n);
	int half;
	int x;
	int y;
	half = width / 2;
	x = int'(CENTER_X) - half + n % width;
	y = int'(CENTER_Y) - half + n % width;
	case (n / width)
		0: y = int'(CENTER_Y) - half;
		1: y = int'(CENTER_Y) + half;
		2: x = int'(CENTER_X) - half;
		default: x = int'(CENTER_X) + half;
	endcase
	return y * int'(SCREEN_WIDTH) + x;
endfunction

function automatic bit lies_on_outline(input int x, input int y, input int width);
	int half;
	half = width / 2;
	return (x == int'(CENTER_X) - half) || (x == int'(CENTER_X) + half)
		|| (y == int'(CENTER_Y) - half) || (y == int'(CENTER_Y) + half);
endfunction

// Strictly inside the walls
function automatic int clamp_inside(input int pos, input int centre, input int half);
	if (pos <= centre - half) begin
		return centre - half + 1;
	end else if (pos >= centre + half) begin
		return centre + half - 1;
	end
	return pos;
endfunction

// Bounce on the axis of travel, then clamp both axes
task automatic move_particle(inout int x, inout int y, inout int h, input int spd,
	input int width, output bit hit);
	int half;
	int dx;
	int dy;
	int cx;
	int cy;
	half = width / 2;
	cx = int'(CENTER_X);
	cy = int'(CENTER_Y);
	dx = (h == 0) ? -spd : (h == 2) ? spd : 0;
	// Up moves toward larger y
	dy = (h == 1) ? spd : (h == 3) ? -spd : 0;
	if (h == 0 || h == 2) begin
		hit = (x + dx >= cx + half) || (x + dx <= cx - half);
	end else begin
		hit = (y + dy >= cy + half) || (y + dy <= cy - half);
	end
	if (hit) begin
		// Left and right swap, as do up and down
		h = h ^ 2;
		dx = -dx;
		dy = -dy;
	end
	x = clamp_inside(x + dx, cx, half);
	y = clamp_inside(y + dy, cy, half);
endtask

`endif

// ==== test/tb_particle_box.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_particle_box;
	import sim_pkg::*;

	localparam int ROWS = 6;
	localparam int TIMEOUT = 30000;
	localparam int MAX_DELAY = 6;

	logic clock;
	logic reset;
	logic step;
	logic [COUNT_W-1:0] num_particles;
	coord_t box_width;
	coord_t speed;
	logic pixel_credit;
	logic pixel_valid;
	pixel_addr_t pixel_addr;
	color_t pixel_color;
	logic step_done;
	logic [COUNT_W-1:0] wall_hits;

	////////////////////
	// Stimulus table
	////////////////////

	// Particles, box width, speed, steps, slow credit return
	// Rows 1 and 2 differ only in credit timing
	int tab_num [ROWS] = '{3, 8, 8, 5, 12, 4};
	int tab_width [ROWS] = '{60, 100, 100, 200, 300, 30};
	int tab_speed [ROWS] = '{4, 7, 7, 15, 40, 3};
	int tab_steps [ROWS] = '{6, 8, 8, 10, 6, 12};
	bit tab_slow [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

	// Monitor state
	pixel_addr_t cap_addr [$];
	color_t cap_color [$];
	int writes_seen;
	int outstanding;
	int done_count;
	int done_hits;
	int mon_errors = 0;
	int mon_checks = 0;

	// Stimulus and model state
	pixel_addr_t exp_addr [$];
	color_t exp_color [$];
	int m_x [MAX_PARTICLES];
	int m_y [MAX_PARTICLES];
	int m_h [MAX_PARTICLES];
	int credits_given;
	int delay;
	bit slow_mode;
	int cap_rd;
	int errors = 0;
	int checks = 0;
	logic [31:0] row_sig;

	particle_box_top particle_box_top_inst (
		.clock(clock),
		.reset(reset),
		.step(step),
		.num_particles(num_particles),
		.box_width(box_width),
		.speed(speed),
		.pixel_credit(pixel_credit),
		.pixel_valid(pixel_valid),
		.pixel_addr(pixel_addr),
		.pixel_color(pixel_color),
		.step_done(step_done),
		.wall_hits(wall_hits)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// Write monitor
	////////////////////

	always @(posedge clock) begin
		if (reset) begin
			cap_addr.delete();
			cap_color.delete();
			writes_seen = 0;
			outstanding = 0;
			done_count = 0;
		end else begin
			if (pixel_credit) begin
				outstanding--;
			end
			if (pixel_valid) begin
				outstanding++;
				writes_seen++;
				cap_addr.push_back(pixel_addr);
				cap_color.push_back(pixel_color);
				mon_checks++;
				// Framebuffer grants only so many slots
				if (outstanding > SINK_CREDITS) begin
					$display("Fail t=%0t outstanding writes: got %0d expected at most %0d",
						$time, outstanding, SINK_CREDITS);
					mon_errors++;
				end
			end
			if (step_done) begin
				done_count++;
				done_hits = int'(wall_hits);
			end
		end
	end

	// One clock with credits handed back on the falling edge
	task automatic cycle();
		@(negedge clock);
		if (!reset && writes_seen > credits_given && (!slow_mode || delay == 0)) begin
			pixel_credit = 1'b1;
			credits_given++;
			if (slow_mode) begin
				delay = int'($urandom % MAX_DELAY);
			end
		end else begin
			pixel_credit = 1'b0;
			if (!reset && writes_seen > credits_given) begin
				delay--;
			end
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		step = 1'b0;
		credits_given = 0;
		delay = 0;
		cap_rd = 0;
		repeat (4) cycle();
		reset = 1'b0;
		checks++;
		if (step_done !== 1'b0) begin
			$display("Fail t=%0t step_done: got %b expected 0", $time, step_done);
			errors++;
		end
		if (wall_hits !== '0) begin
			$display("Fail t=%0t wall_hits: got %0d expected 0", $time, wall_hits);
			errors++;
		end
		if (pixel_valid !== 1'b0) begin
			$display("Fail t=%0t pixel_valid: got %b expected 0", $time, pixel_valid);
			errors++;
		end
	endtask

	// Captured writes against the model in order
	task automatic compare_writes(input string what);
		int got;
		int i;
		got = cap_addr.size() - cap_rd;
		checks++;
		if (got != exp_addr.size()) begin
			$display("Fail t=%0t %s write count: got %0d expected %0d",
				$time, what, got, exp_addr.size());
			errors++;
		end
		for (i = 0; i < exp_addr.size() && cap_rd < cap_addr.size(); i++) begin
			checks++;
			if (cap_addr[cap_rd] !== exp_addr[i]) begin
				$display("Fail t=%0t pixel_addr: got %0d expected %0d",
					$time, cap_addr[cap_rd], exp_addr[i]);
				errors++;
			end
			if (cap_color[cap_rd] !== exp_color[i]) begin
				$display("Fail t=%0t pixel_color: got %h expected %h",
					$time, cap_color[cap_rd], exp_color[i]);
				errors++;
			end
			row_sig = row_sig * 32'd33 + 32'(cap_addr[cap_rd]) + 32'(cap_color[cap_rd]);
			cap_rd++;
		end
		cap_rd = cap_addr.size();
		exp_addr.delete();
		exp_color.delete();
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int r;
		int s;
		int i;
		int n;
		int hits;
		int wait_cnt;
		int row_errors;
		bit row_ok;
		bit hit;
		string mode;
		logic [31:0] prev_sig;
		int unsigned seed;

		seed = $urandom(32'h9daa);
		reset = 1'b1;
		step = 1'b0;
		num_particles = '0;
		box_width = '0;
		speed = '0;
		pixel_credit = 1'b0;
		slow_mode = 1'b0;
		prev_sig = '0;

		for (r = 0; r < ROWS; r++) begin
			row_errors = errors + mon_errors;
			row_ok = 1'b1;
			row_sig = '0;
			slow_mode = tab_slow[r];
			num_particles = COUNT_W'(tab_num[r]);
			box_width = coord_t'(tab_width[r]);
			speed = coord_t'(tab_speed[r]);
			apply_reset();
			n = (tab_num[r] > MAX_PARTICLES) ? MAX_PARTICLES : tab_num[r];
			seed_model(n, tab_width[r]);

			// Outline right after seeding
			for (i = 0; i < 4 * tab_width[r]; i++) begin
				exp_addr.push_back(pixel_addr_t'(outline_addr(tab_width[r], i)));
				exp_color.push_back(COLOR_WHITE);
			end
			wait_cnt = 0;
			while (cap_addr.size() < exp_addr.size() && wait_cnt < TIMEOUT) begin
				cycle();
				wait_cnt++;
			end
			if (cap_addr.size() < exp_addr.size()) begin
				$display("Timeout: the outline writes did not all arrive in row %0d", r);
				errors++;
				row_ok = 1'b0;
			end
			compare_writes("outline");

			for (s = 0; s < tab_steps[r] && row_ok; s++) begin
				// Erase pass skips particles sitting on the outline
				for (i = 0; i < n; i++) begin
					if (!lies_on_outline(m_x[i], m_y[i], tab_width[r])) begin
						exp_addr.push_back(pixel_addr_t'(m_y[i] * int'(SCREEN_WIDTH) + m_x[i]));
						exp_color.push_back(COLOR_BLACK);
					end
				end
				hits = 0;
				for (i = 0; i < n; i++) begin
					move_particle(m_x[i], m_y[i], m_h[i], tab_speed[r], tab_width[r], hit);
					hits += int'(hit);
					exp_addr.push_back(pixel_addr_t'(m_y[i] * int'(SCREEN_WIDTH) + m_x[i]));
					exp_color.push_back(COLOR_WHITE);
				end
				step = 1'b1;
				cycle();
				step = 1'b0;
				wait_cnt = 0;
				while (done_count < s + 1 && wait_cnt < TIMEOUT) begin
					cycle();
					wait_cnt++;
				end
				if (done_count < s + 1) begin
					$display("Timeout: step_done never came for step %0d of row %0d", s, r);
					errors++;
					row_ok = 1'b0;
				end
				compare_writes("step");
				checks++;
				if (row_ok && done_hits != hits) begin
					$display("Fail t=%0t wall_hits: got %0d expected %0d", $time, done_hits, hits);
					errors++;
				end
			end

			// Same row with other credit timing must give the same stream
			if (r > 0 && tab_num[r] == tab_num[r-1] && tab_width[r] == tab_width[r-1]
				&& tab_speed[r] == tab_speed[r-1] && tab_steps[r] == tab_steps[r-1]) begin
				checks++;
				if (row_sig != prev_sig) begin
					$display("Fail t=%0t write stream signature: got %h expected %h",
						$time, row_sig, prev_sig);
					errors++;
				end
			end
			prev_sig = row_sig;

			if (tab_slow[r]) begin
				mode = "slow";
			end else begin
				mode = "prompt";
			end
			$display("Row %0d: %0d particles, width %0d, speed %0d, %s credits, %0d errors",
				r, tab_num[r], tab_width[r], tab_speed[r], mode,
				errors + mon_errors - row_errors);
		end

		$display("Checks: %0d, errors: %0d", checks + mon_checks, errors + mon_errors);
		if (errors + mon_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	`include "tb_model.svh"

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
logic/sim_pkg.sv
logic/pixel_if.sv
logic/particle_if.sv
logic/lfsr_seeder.sv
logic/particle_sequencer.sv
logic/particle_step.sv
logic/pixel_writer.sv
logic/particle_box_top.sv
test/tb_particle_box.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the particle box testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_particle_box \
	-f project.f --Mdir obj_dir -o tb_particle_box

./obj_dir/tb_particle_box > sim.log 2>&1
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
